// File: include/train_config.svh
`ifndef TRAIN_CONFIG_SVH
`define TRAIN_CONFIG_SVH

// --------------------
// classifier dimensions

// characters to pick from
`define N_CLASS 72

// features per input vector
`define N_FEAT 16

// index widths
`define CHAR_LEN 7
`define FEAT_IDX_LEN 4

// --------------------
// arithmetic widths

// signed feature and weight width
`define X_LEN 8

// signed score width, holds N_FEAT full-scale products
`define N_LEN 20

// argmax levels, ceil(log2(N_CLASS))
`define TREE_DEPTH 7

`endif

// File: list.f
+incdir+include
logic/train_pkg.sv
logic/cmd_decode.sv
logic/class_score_mac.sv
logic/pair_select.sv
logic/argmax_tree.sv
logic/char_classifier_top.sv
test/tb_clock.sv
test/tb_char_classifier.sv

// File: logic/argmax_tree.sv
`include "train_config.svh"

module argmax_tree import train_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     run,
  input  logic signed [`N_LEN-1:0] scores [`N_CLASS],
  output logic                     valid,
  output logic [`CHAR_LEN-1:0]     num,
  output logic signed [`N_LEN-1:0] q
);

  localparam int CNT_W = $clog2(`TREE_DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = `TREE_DEPTH;

  // candidates entering each level, tail past the level size tied off
  cand_t            lvl [`TREE_DEPTH+1][`N_CLASS];
  logic [CNT_W-1:0] count;

  // survivors left after l levels
  function automatic int level_size(int l);
    int n;
    n = `N_CLASS;
    for (int i = 0; i < l; i++) begin
      n = (n + 1) / 2;
    end
    return n;
  endfunction

  if (level_size(`TREE_DEPTH) != 1) begin : g_depth_check
    $error("TREE_DEPTH does not reduce N_CLASS to one candidate");
  end

  // --------------------
  // leaves carry their fixed class index
  for (genvar k = 0; k < `N_CLASS; k++) begin : g_leaf
    assign lvl[0][k] = '{num: `CHAR_LEN'(k), q: scores[k]};
  end

  // --------------------
  // reduction levels
  for (genvar l = 0; l < `TREE_DEPTH; l++) begin : g_level
    localparam int N_IN   = level_size(l);
    localparam int N_PAIR = N_IN / 2;
    localparam int N_OUT  = level_size(l + 1);

    for (genvar p = 0; p < N_PAIR; p++) begin : g_pair
      pair_select u_pair_select (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (run),
        .a     (lvl[l][2*p]),
        .b     (lvl[l][2*p+1]),
        .y     (lvl[l+1][p])
      );
    end

    // odd one out waits a cycle so it stays aligned with its peers
    if (N_IN % 2 == 1) begin : g_carry
      cand_t carry_q;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          carry_q <= '0;
        end else if (!run) begin
          carry_q <= '0;
        end else begin
          carry_q <= lvl[l][N_IN-1];
        end
      end

      assign lvl[l+1][N_PAIR] = carry_q;
    end

    for (genvar k = N_OUT; k < `N_CLASS; k++) begin : g_unused
      assign lvl[l+1][k] = '0;
    end
  end

  // --------------------
  // valid counter

  // counts pipeline fill, parks at full depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;
    end else if (!valid) begin
      count <= count + 1'b1;
    end
  end

  assign valid = (count == CNT_FULL);
  assign num   = lvl[`TREE_DEPTH][0].num;
  assign q     = lvl[`TREE_DEPTH][0].q;

  // result only trusted once every level has seen run
  a_valid_fill: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> $past(run, `TREE_DEPTH));

endmodule

// File: logic/char_classifier_top.sv
`include "train_config.svh"

module char_classifier_top import train_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_valid,
  input  cmd_t                     cmd,
  output logic                     err,
  output logic                     valid,
  output logic [`CHAR_LEN-1:0]     num,
  output logic signed [`N_LEN-1:0] q
);

  dec_t                     dec;
  logic signed [`N_LEN-1:0] scores [`N_CLASS];
  logic                     scores_ready;

  // --------------------
  // decode
  cmd_decode u_cmd_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .dec       (dec),
    .err       (err)
  );

  // --------------------
  // score all classes
  class_score_mac u_class_score_mac (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec          (dec),
    .scores       (scores),
    .scores_ready (scores_ready)
  );

  // --------------------
  // pick the winner

  // tree runs for as long as the scores are complete
  argmax_tree u_argmax_tree (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (scores_ready),
    .scores (scores),
    .valid  (valid),
    .num    (num),
    .q      (q)
  );

endmodule

// File: logic/class_score_mac.sv
`include "train_config.svh"

module class_score_mac import train_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  dec_t                     dec,
  output logic signed [`N_LEN-1:0] scores [`N_CLASS],
  output logic                     scores_ready
);

  localparam logic [`FEAT_IDX_LEN:0] FEAT_FULL = `N_FEAT;

  // weight[class][feature]
  logic signed [`X_LEN-1:0]   weight [`N_CLASS][`N_FEAT];
  logic signed [`N_LEN-1:0]   acc    [`N_CLASS];
  logic signed [2*`X_LEN-1:0] prod   [`N_CLASS];
  logic [`FEAT_IDX_LEN:0]     feat_cnt;
  logic                       take_feat;

  // --------------------
  // weight store

  // survives clr, only a write changes it
  always_ff @(posedge clk) begin
    if (dec.wr) begin
      weight[dec.cls][dec.fidx] <= dec.data;
    end
  end

  // --------------------
  // products for every class

  // one column of the weight array times the incoming feature
  always_comb begin
    for (int c = 0; c < `N_CLASS; c++) begin
      prod[c] = weight[c][dec.fidx] * dec.data;
    end
  end

  // --------------------
  // accumulators and feature count

  // vector complete, extra features are dropped
  assign scores_ready = (feat_cnt == FEAT_FULL);
  assign take_feat    = dec.feat && !scores_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < `N_CLASS; c++) begin
        acc[c] <= '0;
      end
      feat_cnt <= '0;
    end else if (dec.clr) begin
      for (int c = 0; c < `N_CLASS; c++) begin
        acc[c] <= '0;
      end
      feat_cnt <= '0;
    end else if (take_feat) begin
      // all classes step together on each feature
      for (int c = 0; c < `N_CLASS; c++) begin
        acc[c] <= acc[c] + prod[c];
      end
      feat_cnt <= feat_cnt + 1'b1;
    end
  end

  assign scores = acc;

  // scores_ready must hold the count at N_FEAT
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
    feat_cnt <= FEAT_FULL);

endmodule

// File: logic/cmd_decode.sv
`include "train_config.svh"

module cmd_decode import train_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_valid,
  input  cmd_t cmd,
  output dec_t dec,
  output logic err
);

  logic                     wr_d;
  logic                     feat_d;
  logic                     clr_d;
  logic                     err_d;
  logic                     cls_ok;
  logic                     wr_q;
  logic                     feat_q;
  logic                     clr_q;
  logic [`CHAR_LEN-1:0]     cls_q;
  logic [`FEAT_IDX_LEN-1:0] fidx_q;
  logic signed [`X_LEN-1:0] data_q;

  // weight writes must land inside the class range
  assign cls_ok = (cmd.cls < `CHAR_LEN'(`N_CLASS));

  // --------------------
  // op to strobe
  always_comb begin
    wr_d   = 1'b0;
    feat_d = 1'b0;
    clr_d  = 1'b0;
    err_d  = 1'b0;
    if (cmd_valid) begin
      case (cmd.op)
        OP_WLOAD: begin
          wr_d  = cls_ok;
          err_d = !cls_ok;
        end
        OP_FEAT:  feat_d = 1'b1;
        OP_CLEAR: clr_d  = 1'b1;
        // idle slot, nothing fires
        OP_NOP: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q   <= 1'b0;
      feat_q <= 1'b0;
      clr_q  <= 1'b0;
      err    <= 1'b0;
    end else begin
      wr_q   <= wr_d;
      feat_q <= feat_d;
      clr_q  <= clr_d;
      err    <= err_d;
    end
  end

  // fields only move when a command comes in
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      cls_q  <= cmd.cls;
      fidx_q <= cmd.fidx;
      data_q <= cmd.data;
    end
  end

  assign dec = '{wr: wr_q, feat: feat_q, clr: clr_q, cls: cls_q, fidx: fidx_q, data: data_q};

  // a rejected write never shows up as a strobe
  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({dec.wr, dec.feat, dec.clr, err}));

endmodule

// File: logic/pair_select.sv
`include "train_config.svh"

module pair_select import train_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  run,
  input  cand_t a,
  input  cand_t b,
  output cand_t y
);

  cand_t win;

  // --------------------
  // compare

  // a wins ties, so the lower index survives
  always_comb begin
    if (b.q > a.q) begin
      win = b;
    end else begin
      win = a;
    end
  end

  // --------------------
  // stage register

  // dropped to zero whenever the tree is idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      y <= '0;
    end else if (!run) begin
      y <= '0;
    end else begin
      y <= win;
    end
  end

endmodule

// File: logic/train_pkg.sv
`include "train_config.svh"

package train_pkg;

  // command opcodes on the input port
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_WLOAD = 2'd1,
    OP_FEAT  = 2'd2,
    OP_CLEAR = 2'd3
  } cmd_op_e;

  // one command as driven from outside
  typedef struct packed {
    cmd_op_e                  op;
    logic [`CHAR_LEN-1:0]     cls;
    logic [`FEAT_IDX_LEN-1:0] fidx;
    logic signed [`X_LEN-1:0] data;
  } cmd_t;

  // decoded command, at most one strobe set
  typedef struct packed {
    logic                     wr;
    logic                     feat;
    logic                     clr;
    logic [`CHAR_LEN-1:0]     cls;
    logic [`FEAT_IDX_LEN-1:0] fidx;
    logic signed [`X_LEN-1:0] data;
  } dec_t;

  // scored candidate moving through the argmax tree
  typedef struct packed {
    logic [`CHAR_LEN-1:0]     num;
    logic signed [`N_LEN-1:0] q;
  } cand_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the classifier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module tb_char_classifier \
  -o sim_char_classifier

./obj_dir/sim_char_classifier > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// File: test/tb_char_classifier.sv
`include "train_config.svh"

module tb_char_classifier import train_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic                     clk;
  logic                     rst_n;
  logic                     cmd_valid;
  cmd_t                     cmd;
  logic                     err;
  logic                     valid;
  logic [`CHAR_LEN-1:0]     num;
  logic signed [`N_LEN-1:0] q;

  // model of the weight store and the current feature vector
  logic signed [`X_LEN-1:0] w_model  [`N_CLASS][`N_FEAT];
  logic signed [`X_LEN-1:0] feat_vec [`N_FEAT];
  logic [31:0]              rng_state = 32'd85854;
  cand_t                    exp_res;
  string                    test_name = "reset";
  int                       n_errors = 0;
  int                       n_checks = 0;
  logic                     valid_seen = 1'b0;

  tb_clock u_tb_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  char_classifier_top u_char_classifier_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .err       (err),
    .valid     (valid),
    .num       (num),
    .q         (q)
  );

  // --------------------
  // helpers

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // dot product per class, first index wins on equal scores
  function automatic cand_t ref_argmax();
    cand_t best;
    int    s;
    best = '0;
    for (int c = 0; c < `N_CLASS; c++) begin
      s = 0;
      for (int f = 0; f < `N_FEAT; f++) begin
        s += w_model[c][f] * feat_vec[f];
      end
      if (c == 0 || s > best.q) begin
        best = '{num: `CHAR_LEN'(c), q: `N_LEN'(s)};
      end
    end
    return best;
  endfunction

  task automatic fail_value(string what, int expv, int actv);
    n_errors++;
    $display("[FAIL] %s: expected %0d, actual %0d", what, expv, actv);
  endtask

  task automatic fail_msg(string text);
    n_errors++;
    $display("[ERROR] %s: %s", test_name, text);
  endtask

  task automatic stop_on_timeout(string what);
    n_errors++;
    $display("[ERROR] %s: timed out waiting for %s", test_name, what);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    $display("TEST FAIL");
    $finish;
  endtask

  // caller sits 2 ns after a rising edge, and is back there on return
  task automatic send_cmd(cmd_op_e op, int cls, int fidx, int data);
    cmd_valid = 1'b1;
    cmd = '{op: op, cls: `CHAR_LEN'(cls), fidx: `FEAT_IDX_LEN'(fidx), data: `X_LEN'(data)};
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
    cmd = '0;
  endtask

  task automatic write_weight(int c, int f, int v);
    send_cmd(OP_WLOAD, c, f, v);
    w_model[c][f] = `X_LEN'(v);
  endtask

  task automatic load_weights(bit zero);
    logic [31:0] r;
    for (int c = 0; c < `N_CLASS; c++) begin
      for (int f = 0; f < `N_FEAT; f++) begin
        r = next_random();
        write_weight(c, f, zero ? 0 : int'($signed(r[7:0])));
      end
    end
  endtask

  // positive features keep the winner predictable in directed cases
  task automatic random_feats(bit positive);
    logic [31:0] r;
    for (int f = 0; f < `N_FEAT; f++) begin
      r = next_random();
      feat_vec[f] = positive ? `X_LEN'({2'b00, r[5:0]} + 8'd1) : r[7:0];
    end
  endtask

  task automatic wait_valid(output int cycles);
    for (int n = 1; n <= 50; n++) begin
      @(posedge clk);
      #1;
      if (valid) begin
        cycles = n;
        #1;
        return;
      end
    end
    stop_on_timeout("valid to rise");
  endtask

  // sends the vector and waits for the tree, checking latency on the way
  task automatic classify(string name);
    int lat;
    test_name = name;
    exp_res = ref_argmax();
    for (int f = 0; f < `N_FEAT; f++) begin
      send_cmd(OP_FEAT, 0, f, feat_vec[f]);
      if (f < `N_FEAT - 1 && valid !== 1'b0) begin
        fail_msg("valid high before the last feature");
      end
    end
    wait_valid(lat);
    if (lat != `TREE_DEPTH + 1) begin
      fail_value({name, " latency"}, `TREE_DEPTH + 1, lat);
    end
  endtask

  task automatic clear_scores();
    send_cmd(OP_CLEAR, 0, 0, 0);
    for (int n = 1; n <= 50; n++) begin
      @(posedge clk);
      #1;
      if (!valid) begin
        if (n > 2) begin
          fail_value({test_name, " clear to valid low"}, 2, n);
        end
        #1;
        return;
      end
    end
    stop_on_timeout("valid to fall after clear");
  endtask

  task automatic wait_reset();
    for (int n = 0; n < 50; n++) begin
      @(posedge clk);
      #2;
      if (rst_n) begin
        return;
      end
    end
    stop_on_timeout("reset release");
  endtask

  // --------------------
  // result compare, once per rising valid
  always @(negedge clk) begin
    if (valid === 1'b1 && !valid_seen) begin
      n_checks++;
      if (num !== exp_res.num) begin
        fail_value({test_name, " num"}, int'(exp_res.num), int'(num));
      end
      if (q !== exp_res.q) begin
        fail_value({test_name, " q"}, int'(exp_res.q), int'(q));
      end
    end
    valid_seen = (valid === 1'b1);
  end

  // --------------------
  // stimulus
  initial begin
    cmd_valid = 1'b0;
    cmd = '0;
    wait_reset();

    if (valid !== 1'b0 || err !== 1'b0) begin
      fail_msg("valid or err not low after reset");
    end

    // random rounds, the first also covers latency out of reset
    for (int r = 0; r < 20; r++) begin
      load_weights(1'b0);
      random_feats(1'b0);
      classify($sformatf("random round %0d", r));
      clear_scores();
    end

    // ties
    load_weights(1'b1);
    random_feats(1'b0);
    classify("all zero weights");
    clear_scores();
    for (int f = 0; f < `N_FEAT; f++) begin
      write_weight(10, f, 5);
      write_weight(40, f, 5);
    end
    random_feats(1'b1);
    classify("tie 10 and 40");
    if (num !== `CHAR_LEN'(10)) begin
      fail_value({test_name, " winner"}, 10, int'(num));
    end

    // clear and reuse, weights stay in place
    test_name = "clear and reuse";
    clear_scores();
    random_feats(1'b1);
    classify("reuse after clear");
    clear_scores();

    // lone winner at the last index rides the odd carry
    load_weights(1'b0);
    for (int f = 0; f < `N_FEAT; f++) begin
      write_weight(71, f, 127);
    end
    random_feats(1'b1);
    classify("odd carry class 71");
    if (num !== `CHAR_LEN'(71)) begin
      fail_value({test_name, " winner"}, 71, int'(num));
    end
    clear_scores();

    // out of range write, model left untouched
    test_name = "bad index";
    send_cmd(OP_WLOAD, 100, 3, 55);
    if (err !== 1'b1) begin
      fail_msg("err did not rise for class index 100");
    end
    random_feats(1'b0);
    classify("after bad write");
    send_cmd(OP_FEAT, 0, 0, 99);
    repeat (3) @(posedge clk);
    #2;
    if (valid !== 1'b1) begin
      fail_msg("valid dropped after an extra feature");
    end
    if (num !== exp_res.num) begin
      fail_value({test_name, " extra feature num"}, int'(exp_res.num), int'(num));
    end
    if (q !== exp_res.q) begin
      fail_value({test_name, " extra feature q"}, int'(exp_res.q), int'(q));
    end
    clear_scores();

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: test/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held for 8 rising edges, released away from the edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
